// ==== xc_cop.f ====
+incdir+include
hw/xc_cop_pkg.sv
hw/cop_cycle_counter.sv
hw/cop_regfile.sv
hw/cop_exec_unit.sv
hw/cop_ctrl_fsm.sv
hw/pcpi_cop_bridge.sv
hw/xc_cop_top.sv
tests/tb_clk_gen.sv
tests/xc_cop_props.sv
tests/tb_xc_cop.sv

// ==== Makefile ====
TOP = tb_xc_cop

sim:
	verilator --binary --assert --timescale 1ns/1ps --top-module $(TOP) -f xc_cop.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || (cat sim.log; exit 1)
	@cat sim.log
	@! grep -q "Simulation FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// ==== tests/tb_xc_cop.sv ====
// Testbench for the XCrypto-style coprocessor
// Plays the PicoRV32 side of PCPI against a shadow register model
`timescale 1ns/1ps
`include "xc_cop_defines.svh"

module tb_xc_cop;
  import xc_cop_pkg::*;

  localparam int N_TESTS     = 334;                  // Instructions and unclaimed probes
  localparam int READY_LIMIT = 64;                   // Cycles one instruction may take
  localparam int WDOG_CYCLES = N_TESTS * 40 + 200;

  logic                clk;
  logic                rst;
  logic                pcpi_valid;
  logic [`XC_XLEN-1:0] pcpi_insn;
  logic [`XC_XLEN-1:0] pcpi_rs1;
  logic [`XC_XLEN-1:0] pcpi_rs2;
  logic                pcpi_wr;
  logic [`XC_XLEN-1:0] pcpi_rd;
  logic                pcpi_wait;
  logic                pcpi_ready;

  logic [`XC_XLEN-1:0] shadow [`XC_NCREG]; // Expected COP registers
  logic [`XC_XLEN-1:0] exp_rd_q [$];       // Replies in issue order
  logic                exp_wr_q [$];
  logic [31:0]         lfsr   = 32'hafe1_f5b9;
  int                  errors = 0;
  int                  checks = 0;

  tb_clk_gen u_clk (.clk(clk));

  xc_cop_top DUT (
    .clk        (clk),
    .rst        (rst),
    .pcpi_valid (pcpi_valid),
    .pcpi_insn  (pcpi_insn),
    .pcpi_rs1   (pcpi_rs1),
    .pcpi_rs2   (pcpi_rs2),
    .pcpi_wr    (pcpi_wr),
    .pcpi_rd    (pcpi_rd),
    .pcpi_wait  (pcpi_wait),
    .pcpi_ready (pcpi_ready)
  );

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] make_insn(cop_op_e op, logic [3:0] crd, logic [3:0] crs1,
                                            logic [3:0] crs2, logic [4:0] sh);
    logic [31:0] insn;
    insn               = '0;
    insn[`XC_F_OPCODE] = `XC_OPC_CUSTOM0;
    insn[`XC_F_CRD]    = crd;
    insn[`XC_F_FUNCT3] = op;
    insn[`XC_F_CRS1]   = crs1;
    insn[`XC_F_CRS2]   = crs2;
    insn[`XC_F_SHAMT]  = sh;
    return insn;
  endfunction

  // Expected operation result from the COP instruction rules
  function automatic logic [31:0] model_result(cop_op_e op, logic [31:0] gpr,
                                               logic [31:0] a, logic [31:0] b,
                                               logic [4:0] sh);
    logic [63:0] dbl;
    dbl = {a, a} << sh; // Upper half is a rotated left by sh
    case (op)
      OP_MV2COP: return gpr;
      OP_MV2GPR: return a;
      OP_XOR:    return a ^ b;
      OP_ADD:    return a + b;
      OP_ROTL:   return dbl[63:32];
      default:   return 32'h0;
    endcase
  endfunction

  task automatic check_val(string name, logic [31:0] exp, logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("[ERROR] t=%0t %s expected %08h got %08h", $time, name, exp, act);
    end
  endtask

  // Issue one instruction and wait for its finish pulse
  task automatic issue(cop_op_e op, logic [3:0] crd, logic [3:0] crs1, logic [3:0] crs2,
                       logic [4:0] sh, logic [31:0] gpr, bit check_lat, bit hold);
    logic [31:0] res;
    int          waited;
    int          exp_lat;
    res     = model_result(op, gpr, shadow[crs1], shadow[crs2], sh);
    exp_lat = (op == OP_ROTL) ? 2 + int'(sh) : 2; // One extra cycle per rotate step
    exp_rd_q.push_back((op == OP_MV2GPR) ? res : '0);
    exp_wr_q.push_back(op == OP_MV2GPR);
    if (op != OP_MV2GPR) begin
      shadow[crd] = res;
    end
    @(posedge clk);
    #1;
    pcpi_valid = 1'b1;
    pcpi_insn  = make_insn(op, crd, crs1, crs2, sh);
    pcpi_rs1   = gpr;
    pcpi_rs2   = rand_bits(32); // Not read by any operation
    waited     = 0;
    @(negedge clk);
    while (!pcpi_ready && waited < READY_LIMIT) begin
      check_val("pcpi_wait", 32'd1, {31'd0, pcpi_wait}); // Busy until the finish pulse
      waited++;
      @(negedge clk);
    end
    if (!pcpi_ready) begin
      errors++;
      $display("No pcpi_ready within %0d cycles for %s at %0t", READY_LIMIT, op.name(), $time);
      exp_rd_q.delete();
      exp_wr_q.delete();
    end else if (check_lat) begin
      check_val("pcpi_ready latency", 32'(exp_lat), 32'(waited));
    end
    if (!hold) begin
      @(posedge clk);
      #1;
      pcpi_valid = 1'b0;
    end
  endtask

  task automatic readback_all();
    for (int r = 0; r < `XC_NCREG; r++) begin
      issue(OP_MV2GPR, 4'(rand_bits(4)), 4'(r), 4'(rand_bits(4)), 5'(rand_bits(5)),
            rand_bits(32), 1'b1, 1'b0);
    end
  endtask

  // Hold a foreign instruction and watch the coprocessor stay quiet
  task automatic unclaimed_probe(logic [31:0] insn, string what);
    @(posedge clk);
    #1;
    pcpi_valid = 1'b1;
    pcpi_insn  = insn;
    pcpi_rs1   = rand_bits(32);
    repeat (20) begin
      @(negedge clk);
      check_val({what, " pcpi_wait"}, 32'd0, {31'd0, pcpi_wait});
      check_val({what, " pcpi_ready"}, 32'd0, {31'd0, pcpi_ready});
    end
    @(posedge clk);
    #1;
    pcpi_valid = 1'b0; // CPU traps it elsewhere
  endtask

  task automatic finish_run();
    int total;
    total = errors + DUT.u_props.assert_fails;
    $display("Checks %0d  mismatches %0d  assertion failures %0d",
             checks, errors, DUT.u_props.assert_fails);
    if (total == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  // Compare every reply with the model at the ready cycle
  always @(negedge clk) begin : compare
    logic        exp_wr;
    logic [31:0] exp_rd;
    if (!rst && pcpi_ready) begin
      if (exp_rd_q.size() == 0) begin
        errors++;
        $display("pcpi_ready raised with no instruction pending at %0t", $time);
      end else begin
        exp_wr = exp_wr_q.pop_front();
        exp_rd = exp_rd_q.pop_front();
        check_val("pcpi_wr", {31'd0, exp_wr}, {31'd0, pcpi_wr});
        check_val("pcpi_rd", exp_rd, pcpi_rd);
      end
    end
  end

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    errors++;
    $display("Watchdog expired after %0d cycles before the tests completed", WDOG_CYCLES);
    finish_run();
  end

  initial begin
    cop_op_e     op;
    logic [3:0]  a;
    logic [3:0]  b;
    logic [3:0]  d;
    logic [4:0]  sh;
    logic [31:0] insn;
    rst        = 1'b1;
    pcpi_valid = 1'b0;
    pcpi_insn  = '0;
    pcpi_rs1   = '0;
    pcpi_rs2   = '0;
    for (int r = 0; r < `XC_NCREG; r++) begin
      shadow[r] = '0; // Regfile clears on reset
    end
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_val("pcpi_wait", 32'd0, {31'd0, pcpi_wait});
    check_val("pcpi_ready", 32'd0, {31'd0, pcpi_ready});
    check_val("pcpi_wr", 32'd0, {31'd0, pcpi_wr});
    readback_all();

    // Move round trip
    for (int i = 0; i < 16; i++) begin
      issue(OP_MV2COP, 4'(rand_bits(4)), 4'd0, 4'd0, 5'd0, rand_bits(32), 1'b1, 1'b0);
    end
    readback_all();

    // XOR and ADD with a shared source on every fourth
    for (int i = 0; i < 12; i++) begin
      op = (i % 2 == 0) ? OP_XOR : OP_ADD;
      a  = 4'(rand_bits(4));
      b  = (i % 4 == 0) ? a : 4'(rand_bits(4));
      issue(op, 4'(rand_bits(4)), a, b, 5'(rand_bits(5)), rand_bits(32), 1'b1, 1'b0);
    end
    readback_all();

    // Rotate with edge amounts first
    for (int i = 0; i < 8; i++) begin
      case (i)
        0:       sh = 5'd0;
        1:       sh = 5'd1;
        2:       sh = 5'd31;
        default: sh = 5'(rand_bits(5));
      endcase
      a = 4'(rand_bits(4));
      d = 4'(rand_bits(4));
      issue(OP_MV2COP, a, 4'd0, 4'd0, 5'd0, rand_bits(32), 1'b1, 1'b0); // Fresh operand
      issue(OP_ROTL, d, a, 4'(rand_bits(4)), sh, rand_bits(32), 1'b1, 1'b0);
      issue(OP_MV2GPR, 4'd0, d, 4'd0, 5'd0, rand_bits(32), 1'b1, 1'b0);
    end

    // Instructions the bridge must ignore
    insn              = make_insn(OP_ADD, 4'd1, 4'd2, 4'd3, 5'd0);
    insn[`XC_F_OPCODE] = 7'b0110011; // Base OP major opcode
    unclaimed_probe(insn, "standard opcode");
    insn              = make_insn(OP_XOR, 4'd1, 4'd2, 4'd3, 5'd0);
    insn[`XC_F_FUNCT3] = 3'd6;
    unclaimed_probe(insn, "illegal funct3");
    readback_all();

    // Back-to-back with valid held high
    for (int i = 0; i < 200; i++) begin
      op = cop_op_e'(3'(rand_bits(3) % 5));
      issue(op, 4'(rand_bits(4)), 4'(rand_bits(4)), 4'(rand_bits(4)), 5'(rand_bits(5)),
            rand_bits(32), 1'b0, 1'b1);
    end
    @(posedge clk);
    #1;
    pcpi_valid = 1'b0;
    readback_all();
    finish_run();
  end

endmodule

// ==== tests/xc_cop_props.sv ====
// PCPI reply checks for the coprocessor top level
// Bound into every xc_cop_top instance
`timescale 1ns/1ps

module xc_cop_props (
  input logic clk,
  input logic rst,
  input logic pcpi_valid,
  input logic pcpi_wr,
  input logic pcpi_wait,
  input logic pcpi_ready,
  input logic insn_ack
);

  int assert_fails = 0; // Read by the testbench summary

  // Finish pulse lasts one cycle
  a_ready_pulse: assert property (@(posedge clk) disable iff (rst)
    pcpi_ready |=> !pcpi_ready)
    else begin
      assert_fails++;
      $error("pcpi_ready stayed high for more than one cycle");
    end

  a_wait_ready_excl: assert property (@(posedge clk) disable iff (rst)
    !(pcpi_wait && pcpi_ready))
    else begin
      assert_fails++;
      $error("pcpi_wait and pcpi_ready high together");
    end

  // GPR write only with the finish pulse
  a_wr_with_ready: assert property (@(posedge clk) disable iff (rst)
    pcpi_wr |-> pcpi_ready)
    else begin
      assert_fails++;
      $error("pcpi_wr high without pcpi_ready");
    end

  a_quiet_no_valid: assert property (@(posedge clk) disable iff (rst)
    !pcpi_valid |-> !(pcpi_wait || pcpi_ready || pcpi_wr || insn_ack))
    else begin
      assert_fails++;
      $error("Coprocessor active while pcpi_valid is low");
    end

endmodule

bind xc_cop_top xc_cop_props u_props (
  .clk        (clk),
  .rst        (rst),
  .pcpi_valid (pcpi_valid),
  .pcpi_wr    (pcpi_wr),
  .pcpi_wait  (pcpi_wait),
  .pcpi_ready (pcpi_ready),
  .insn_ack   (insn_ack)
);

// ==== tests/tb_clk_gen.sv ====
// Testbench clock source
// Free-running clock with a 10 ns period
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int HALF_PERIOD = 5 // ns
) (
  output logic clk
);

  initial clk = 1'b0;

  always #HALF_PERIOD clk = ~clk;

endmodule

// ==== hw/xc_cop_top.sv ====
// XCrypto-style coprocessor top level
// PCPI bridge, control FSM, iteration counter, execution unit
// and COP register file
`timescale 1ns/1ps
`include "xc_cop_defines.svh"

module xc_cop_top (
  input  logic                clk,
  input  logic                rst,
  input  logic                pcpi_valid,
  input  logic [`XC_XLEN-1:0] pcpi_insn,
  input  logic [`XC_XLEN-1:0] pcpi_rs1,
  input  logic [`XC_XLEN-1:0] pcpi_rs2,   // No operation reads rs2
  output logic                pcpi_wr,
  output logic [`XC_XLEN-1:0] pcpi_rd,
  output logic                pcpi_wait,
  output logic                pcpi_ready
);
  import xc_cop_pkg::*;

  // Bridge to FSM and datapath
  logic                insn_req;
  cop_op_e             op;
  logic [3:0]          crd;
  logic [3:0]          crs1;
  logic [3:0]          crs2;
  logic [4:0]          shamt;
  logic [`XC_XLEN-1:0] rs1_data;

  // FSM strobes
  logic                insn_ack;  // Accept pulse, watched by the bound checks
  logic                insn_rsp;
  logic                insn_wr;
  logic                cnt_load;
  logic                cnt_done;
  logic                exec_load;
  logic                exec_step;
  logic                rf_we;

  // Datapath
  logic [`XC_XLEN-1:0] crs1_val;
  logic [`XC_XLEN-1:0] crs2_val;
  logic [`XC_XLEN-1:0] result;

  pcpi_cop_bridge u_bridge (
    .pcpi_valid (pcpi_valid),
    .pcpi_insn  (pcpi_insn),
    .pcpi_rs1   (pcpi_rs1),
    .insn_rsp   (insn_rsp),
    .insn_wr    (insn_wr),
    .result     (result),
    .pcpi_wr    (pcpi_wr),
    .pcpi_rd    (pcpi_rd),
    .pcpi_wait  (pcpi_wait),
    .pcpi_ready (pcpi_ready),
    .insn_req   (insn_req),
    .op         (op),
    .crd        (crd),
    .crs1       (crs1),
    .crs2       (crs2),
    .shamt      (shamt),
    .rs1_data   (rs1_data)
  );

  cop_ctrl_fsm u_fsm (
    .clk        (clk),
    .rst        (rst),
    .insn_req   (insn_req),
    .op         (op),
    .cnt_done   (cnt_done),
    .pcpi_valid (pcpi_valid),
    .insn_ack   (insn_ack),
    .insn_rsp   (insn_rsp),
    .insn_wr    (insn_wr),
    .cnt_load   (cnt_load),
    .exec_load  (exec_load),
    .exec_step  (exec_step),
    .rf_we      (rf_we)
  );

  cop_cycle_counter u_cnt (
    .clk      (clk),
    .rst      (rst),
    .cnt_load (cnt_load),
    .shamt    (shamt),
    .cnt_done (cnt_done)
  );

  cop_exec_unit u_exec (
    .clk       (clk),
    .rst       (rst),
    .exec_load (exec_load),
    .exec_step (exec_step),
    .op        (op),
    .rs1_data  (rs1_data),
    .crs1_val  (crs1_val),
    .crs2_val  (crs2_val),
    .result    (result)
  );

  // Write address is crd, held by the CPU until ready
  cop_regfile u_rf (
    .clk    (clk),
    .rst    (rst),
    .we     (rf_we),
    .waddr  (crd),
    .wdata  (result),
    .raddr1 (crs1),
    .raddr2 (crs2),
    .rdata1 (crs1_val),
    .rdata2 (crs2_val)
  );

endmodule

// ==== hw/pcpi_cop_bridge.sv ====
// PCPI to coprocessor bridge
// Claims custom-0 instructions with a legal funct3, slices out the
// register fields and builds the PCPI reply from the finish strobes
`timescale 1ns/1ps
`include "xc_cop_defines.svh"

module pcpi_cop_bridge (
  input  logic                 pcpi_valid,
  input  logic [`XC_XLEN-1:0]  pcpi_insn,
  input  logic [`XC_XLEN-1:0]  pcpi_rs1,
  input  logic                 insn_rsp,
  input  logic                 insn_wr,
  input  logic [`XC_XLEN-1:0]  result,
  output logic                 pcpi_wr,
  output logic [`XC_XLEN-1:0]  pcpi_rd,
  output logic                 pcpi_wait,
  output logic                 pcpi_ready,
  output logic                 insn_req,
  output xc_cop_pkg::cop_op_e  op,
  output logic [3:0]           crd,
  output logic [3:0]           crs1,
  output logic [3:0]           crs2,
  output logic [4:0]           shamt,
  output logic [`XC_XLEN-1:0]  rs1_data
);
  import xc_cop_pkg::*;

  logic opc_hit; // Major opcode is custom-0
  logic fn3_ok;  // funct3 names a COP operation

  assign opc_hit = (pcpi_insn[`XC_F_OPCODE] == `XC_OPC_CUSTOM0);
  assign op      = cop_op_e'(pcpi_insn[`XC_F_FUNCT3]);

  always_comb begin
    case (op)
      OP_MV2COP, OP_MV2GPR, OP_XOR, OP_ADD, OP_ROTL: fn3_ok = 1'b1;
      default: fn3_ok = 1'b0; // Unused codes left for the CPU to trap
    endcase
  end

  // Request level to the FSM
  assign insn_req = pcpi_valid && opc_hit && fn3_ok;

  // Field slices, held stable by the CPU until ready
  assign crd      = pcpi_insn[`XC_F_CRD];
  assign crs1     = pcpi_insn[`XC_F_CRS1];
  assign crs2     = pcpi_insn[`XC_F_CRS2];
  assign shamt    = pcpi_insn[`XC_F_SHAMT];
  assign rs1_data = pcpi_rs1;

  // PCPI reply
  assign pcpi_ready = insn_rsp;
  assign pcpi_wr    = insn_wr;
  assign pcpi_rd    = insn_wr ? result : '0;       // Zero unless writing rd
  assign pcpi_wait  = insn_req && !insn_rsp;       // Busy until the finish pulse

endmodule

// ==== hw/cop_ctrl_fsm.sv ====
// Coprocessor control FSM
// Walks IDLE, EXEC, optional ROT, RESP and DROP for each claimed
// instruction and raises the datapath and write-back strobes
`timescale 1ns/1ps

module cop_ctrl_fsm (
  input  logic                clk,
  input  logic                rst,
  input  logic                insn_req,
  input  xc_cop_pkg::cop_op_e op,
  input  logic                cnt_done,
  input  logic                pcpi_valid,
  output logic                insn_ack,
  output logic                insn_rsp,
  output logic                insn_wr,
  output logic                cnt_load,
  output logic                exec_load,
  output logic                exec_step,
  output logic                rf_we
);
  import xc_cop_pkg::*;

  cop_state_e state;     // Current state
  cop_state_e state_nxt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (insn_ack) begin
          state_nxt = EXEC;
        end
      end
      EXEC: begin
        if (!pcpi_valid) begin
          state_nxt = IDLE;                         // Request withdrawn, no write
        end else if (op == OP_ROTL && !cnt_done) begin
          state_nxt = ROT;                          // Nonzero rotate amount
        end else begin
          state_nxt = RESP;
        end
      end
      ROT: begin
        if (!pcpi_valid) begin
          state_nxt = IDLE;
        end else if (cnt_done) begin
          state_nxt = RESP;                         // Last step taken this cycle
        end
      end
      RESP:    state_nxt = DROP;
      DROP:    state_nxt = IDLE;                    // CPU swaps or drops insn here
      default: state_nxt = IDLE;
    endcase
  end

  // Accept pulse
  assign insn_ack = (state == IDLE) && insn_req;

  // Counter loaded on accept so EXEC already counts one step
  assign cnt_load = insn_ack;

  // Datapath strobes
  assign exec_load = (state == EXEC);
  assign exec_step = (state == ROT);

  // Finish pulse and write back
  assign insn_rsp = (state == RESP);
  assign insn_wr  = insn_rsp && (op == OP_MV2GPR); // Result to GPR rd
  assign rf_we    = insn_rsp && (op != OP_MV2GPR); // Result to COP crd

endmodule

// ==== hw/cop_exec_unit.sv ====
// Coprocessor execution unit
// Result register loaded from the selected operation,
// then rotated left one bit per step for OP_ROTL
`timescale 1ns/1ps
`include "xc_cop_defines.svh"

module cop_exec_unit (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 exec_load,
  input  logic                 exec_step,
  input  xc_cop_pkg::cop_op_e  op,
  input  logic [`XC_XLEN-1:0]  rs1_data,
  input  logic [`XC_XLEN-1:0]  crs1_val,
  input  logic [`XC_XLEN-1:0]  crs2_val,
  output logic [`XC_XLEN-1:0]  result
);
  import xc_cop_pkg::*;

  logic [`XC_XLEN-1:0] op_val; // Single-cycle result
  logic [`XC_XLEN-1:0] rot1;   // Result rotated by one

  always_comb begin
    case (op)
      OP_MV2COP: op_val = rs1_data;            // From the CPU
      OP_XOR:    op_val = crs1_val ^ crs2_val;
      OP_ADD:    op_val = crs1_val + crs2_val; // Carry out dropped
      default:   op_val = crs1_val;            // MV2GPR and ROTL start value
    endcase
  end

  assign rot1 = {result[`XC_XLEN-2:0], result[`XC_XLEN-1]};

  // Load wins over step, the FSM never asks for both
  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else if (exec_load) begin
      result <= op_val;
    end else if (exec_step) begin
      result <= rot1;
    end
  end

endmodule

// ==== hw/cop_regfile.sv ====
// Coprocessor register file
// 16 x 32 bits, two combinational read ports, one synchronous write
// c0 is an ordinary register
`timescale 1ns/1ps
`include "xc_cop_defines.svh"

module cop_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 we,
  input  logic [3:0]           waddr,
  input  logic [`XC_XLEN-1:0]  wdata,
  input  logic [3:0]           raddr1,
  input  logic [3:0]           raddr2,
  output logic [`XC_XLEN-1:0]  rdata1,
  output logic [`XC_XLEN-1:0]  rdata2
);

  logic [`XC_XLEN-1:0] regs [`XC_NCREG];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `XC_NCREG; i++) begin
        regs[i] <= '0; // All registers start at zero
      end
    end else if (we) begin
      regs[waddr] <= wdata;
    end
  end

  // Read ports, no bypass of a same-cycle write
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

// ==== hw/cop_cycle_counter.sv ====
// Iteration counter for multi-cycle operations
// Loaded with the rotate amount on accept, counts down to zero
`timescale 1ns/1ps

module cop_cycle_counter (
  input  logic       clk,
  input  logic       rst,
  input  logic       cnt_load,
  input  logic [4:0] shamt,
  output logic       cnt_done
);

  logic [4:0] count; // Steps still to run

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else if (cnt_load) begin
      count <= shamt;
    end else if (count != '0) begin
      count <= count - 5'd1; // Stops at zero
    end
  end

  // Zero load finishes at once
  assign cnt_done = (count == '0);

endmodule

// ==== hw/xc_cop_pkg.sv ====
// XCrypto coprocessor shared types
// Control FSM states and the operation codes decoded from funct3
package xc_cop_pkg;

  // Control FSM states
  typedef enum logic [2:0] {
    IDLE = 3'd0, // Waiting for a claimed instruction
    EXEC = 3'd1, // Operand capture
    ROT  = 3'd2, // One rotate step per cycle
    RESP = 3'd3, // Finish pulse and write back
    DROP = 3'd4  // Give the CPU a cycle to move on
  } cop_state_e;

  // Operation codes
  // Values match funct3 so the decode is a plain cast
  typedef enum logic [2:0] {
    OP_MV2COP = 3'd0, // GPR rs1 into COP register
    OP_MV2GPR = 3'd1, // COP register back to GPR rd
    OP_XOR    = 3'd2,
    OP_ADD    = 3'd3, // Wraps at 32 bits
    OP_ROTL   = 3'd4  // Rotate left by the immediate
  } cop_op_e;

  // funct3 codes 5..7 are not claimed by the bridge

endpackage

// ==== include/xc_cop_defines.svh ====
// XCrypto coprocessor constants
// Widths, register count and instruction field positions
`ifndef XC_COP_DEFINES_SVH
`define XC_COP_DEFINES_SVH

// Datapath width
`define XC_XLEN 32

// COP register count, indexed by 4 bits
`define XC_NCREG 16

// Major opcode claimed by the bridge
`define XC_OPC_CUSTOM0 7'b0001011

// Instruction field slices
`define XC_F_OPCODE 6:0
`define XC_F_CRD    10:7   // Low 4 bits of rd
`define XC_F_FUNCT3 14:12  // Operation select
`define XC_F_CRS1   18:15  // Low 4 bits of rs1
`define XC_F_CRS2   23:20  // Low 4 bits of rs2
`define XC_F_SHAMT  29:25  // Rotate amount in funct7

`endif
